// ==== uart_alu_pkg.sv ====
package uart_alu_pkg;

  //////////////////////////////
  // Widths and constants.
  //////////////////////////////

  localparam int TICKS_PER_BIT = 16;   // Oversampling factor.

  typedef logic [7:0] data_word_t;     // UART byte, operand or result.

  //////////////////////////////
  // ALU opcodes.
  //////////////////////////////

  typedef enum logic [7:0] {
    ADD = 8'h20,
    SUB = 8'h22,
    AND = 8'h24,
    OR  = 8'h25,
    XOR = 8'h26,
    NOR = 8'h27,
    SRA = 8'h03,                       // Arithmetic shift right.
    SRL = 8'h02                        // Logical shift right.
  } opcode_t;

  // Operand bundle, 24 bits.
  typedef struct packed {
    data_word_t a;                     // First byte received.
    data_word_t b;                     // Second byte.
    opcode_t    opcode;                // Third byte.
  } alu_operands_t;

  // Interface FSM.
  typedef enum logic [2:0] {
    WAIT_A,
    WAIT_B,
    WAIT_OP,
    START_TX,
    WAIT_TX
  } iface_state_t;

endpackage

// ==== baud_rate_generator.sv ====
`timescale 1ns/100ps

module baud_rate_generator import uart_alu_pkg::*; #(
  parameter int FREC_CLOCK_HZ = 100000000,  // System clock.
  parameter int BAUD_RATE     = 9600        // Serial line rate.
) (
  input  logic i_clock,
  input  logic i_reset,
  output logic o_rate                       // One tick, 16 per bit.
);

  // Clocks per tick, rounded down.
  localparam int DIVISOR = FREC_CLOCK_HZ / (BAUD_RATE * TICKS_PER_BIT);
  localparam int CNT_W   = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DIVISOR - 1);

  logic [CNT_W-1:0] count;                  // Down counter.

  // Free-running, wraps every DIVISOR clocks.
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      count  <= RELOAD;
      o_rate <= 1'b0;
    end else if (count == '0) begin
      count  <= RELOAD;                     // Wrap.
      o_rate <= 1'b1;                       // Tick on wrap.
    end else begin
      count  <= count - 1'b1;
      o_rate <= 1'b0;
    end
  end

endmodule

// ==== uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx import uart_alu_pkg::*; (
  input  logic       i_clock,
  input  logic       i_reset,
  input  logic       i_rate,       // Oversampling tick.
  input  logic       i_bit_rx,     // Serial line in.
  output logic       o_rx_done,    // One-cycle pulse per byte.
  output data_word_t o_data_out    // Held until next byte.
);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

  localparam int TICK_W = $clog2(TICKS_PER_BIT);
  localparam logic [TICK_W-1:0] MID_TICK  = TICK_W'(TICKS_PER_BIT / 2 - 1);
  localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(TICKS_PER_BIT - 1);

  rx_state_t         state;
  logic [TICK_W-1:0] tick_cnt;     // Ticks within a bit.
  logic [2:0]        bit_cnt;      // Data bit index.
  data_word_t        shreg;        // Incoming bits, LSB first.

  //////////////////////////////
  // Control.
  //////////////////////////////

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      state     <= RX_IDLE;
      tick_cnt  <= '0;
      bit_cnt   <= '0;
      o_rx_done <= 1'b0;
    end else begin
      o_rx_done <= 1'b0;                        // Pulse default.
      case (state)
        RX_IDLE: begin
          tick_cnt <= '0;
          if (!i_bit_rx) state <= RX_START;     // Falling edge seen.
        end
        RX_START: if (i_rate) begin
          if (tick_cnt == MID_TICK) begin
            tick_cnt <= '0;
            bit_cnt  <= '0;
            // Still low at mid-bit, a real start.
            state    <= i_bit_rx ? RX_IDLE : RX_DATA;
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        RX_DATA: if (i_rate) begin
          if (tick_cnt == LAST_TICK) begin
            tick_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) state <= RX_STOP;  // Last data bit.
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        RX_STOP: if (i_rate) begin
          if (tick_cnt == LAST_TICK) begin      // Middle of stop bit.
            o_rx_done <= 1'b1;
            state     <= RX_IDLE;
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Data path.
  //////////////////////////////

  always_ff @(posedge i_clock) begin
    if (state == RX_DATA && i_rate && tick_cnt == LAST_TICK)
      shreg <= {i_bit_rx, shreg[7:1]};           // Sample at mid-bit.
    if (state == RX_STOP && i_rate && tick_cnt == LAST_TICK)
      o_data_out <= shreg;                       // Publish byte.
  end

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx import uart_alu_pkg::*; #(
  parameter int STOP_BITS = 2              // 1 or 2.
) (
  input  logic       i_clock,
  input  logic       i_reset,
  input  logic       i_rate,               // Oversampling tick.
  input  logic       i_tx_start,           // Only while idle.
  input  data_word_t i_data_in,
  output logic       o_bit_tx,             // Serial line out.
  output logic       o_tx_done             // End of last stop bit.
);

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_SYNC,                               // Wait for first tick.
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  localparam int TICK_W = $clog2(TICKS_PER_BIT);
  localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(TICKS_PER_BIT - 1);
  localparam logic [2:0]        LAST_STOP = 3'(STOP_BITS - 1);

  tx_state_t         state;
  logic [TICK_W-1:0] tick_cnt;
  logic [2:0]        bit_cnt;              // Data bit, then stop bit index.
  data_word_t        shreg;                // Bits left to send.

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      state     <= TX_IDLE;
      tick_cnt  <= '0;
      bit_cnt   <= '0;
      o_bit_tx  <= 1'b1;                   // Line idles high.
      o_tx_done <= 1'b0;
    end else begin
      o_tx_done <= 1'b0;
      case (state)
        TX_IDLE: if (i_tx_start) state <= TX_SYNC;
        TX_SYNC: if (i_rate) begin
          o_bit_tx <= 1'b0;                // Start bit.
          tick_cnt <= '0;
          state    <= TX_START;
        end
        TX_START, TX_DATA, TX_STOP: if (i_rate) begin
          tick_cnt <= tick_cnt + 1'b1;     // Wraps after 16 ticks.
          if (tick_cnt == LAST_TICK) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (state == TX_START) begin
              o_bit_tx <= shreg[0];
              bit_cnt  <= '0;
              state    <= TX_DATA;
            end else if (state == TX_DATA) begin
              o_bit_tx <= (bit_cnt == 3'd7) ? 1'b1 : shreg[1];
              if (bit_cnt == 3'd7) begin
                bit_cnt <= '0;
                state   <= TX_STOP;
              end
            end else if (bit_cnt == LAST_STOP) begin
              o_tx_done <= 1'b1;           // Frame complete.
              state     <= TX_IDLE;
            end
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  // Load on start, shift at each data bit boundary.
  always_ff @(posedge i_clock) begin
    if (state == TX_IDLE && i_tx_start)
      shreg <= i_data_in;
    else if (state == TX_DATA && i_rate && tick_cnt == LAST_TICK)
      shreg <= {1'b0, shreg[7:1]};
  end

endmodule

// ==== alu.sv ====
`timescale 1ns/100ps

module alu import uart_alu_pkg::*; (
  input  alu_operands_t i_operands,   // A, B and opcode.
  output data_word_t    o_result
);

  data_word_t a;
  data_word_t b;
  logic [2:0] shamt;                  // Shift amount from B.

  assign a     = i_operands.a;
  assign b     = i_operands.b;
  assign shamt = i_operands.b[2:0];

  //////////////////////////////
  // Operation decode.
  //////////////////////////////

  always_comb begin
    case (i_operands.opcode)
      ADD:     o_result = a + b;                      // Wraps mod 256.
      SUB:     o_result = a - b;
      AND:     o_result = a & b;
      OR:      o_result = a | b;
      XOR:     o_result = a ^ b;
      NOR:     o_result = ~(a | b);
      SRA:     o_result = data_word_t'($signed(a) >>> shamt);  // Sign fill.
      SRL:     o_result = a >> shamt;                 // Zero fill.
      default: o_result = 8'h00;                      // Unknown opcode.
    endcase
  end

endmodule

// ==== interface_circuit.sv ====
`timescale 1ns/100ps

module interface_circuit import uart_alu_pkg::*; (
  input  logic          i_clock,
  input  logic          i_reset,
  input  logic          i_rx_done,     // Byte received.
  input  logic          i_tx_done,     // Reply sent.
  input  data_word_t    i_data_rx,
  input  data_word_t    i_result,      // From ALU.
  output alu_operands_t o_operands,    // To ALU.
  output logic          o_tx_start,
  output data_word_t    o_data_tx
);

  iface_state_t state;

  //////////////////////////////
  // Byte collection FSM.
  //////////////////////////////

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      state      <= WAIT_A;
      o_operands <= '0;
    end else begin
      case (state)
        WAIT_A: if (i_rx_done) begin
          o_operands.a <= i_data_rx;   // First operand.
          state        <= WAIT_B;
        end
        WAIT_B: if (i_rx_done) begin
          o_operands.b <= i_data_rx;
          state        <= WAIT_OP;
        end
        WAIT_OP: if (i_rx_done) begin
          o_operands.opcode <= opcode_t'(i_data_rx);
          state             <= START_TX;
        end
        START_TX: state <= WAIT_TX;    // Single start cycle.
        WAIT_TX: begin
          // Bytes arriving here are dropped.
          if (i_tx_done) state <= WAIT_A;
        end
        default: state <= WAIT_A;
      endcase
    end
  end

  //////////////////////////////
  // Transmit launch.
  //////////////////////////////

  // Start pulse decoded from the state register, one cycle after the opcode.
  assign o_tx_start = (state == START_TX);

  // Result of the registered operand bundle, latched by the transmitter.
  assign o_data_tx = i_result;

endmodule

// ==== top_arquitectura.sv ====
`timescale 1ns/100ps

module top_arquitectura import uart_alu_pkg::*; #(
  parameter int FREC_CLOCK_HZ = 100000000,
  parameter int BAUD_RATE     = 9600,
  parameter int STOP_BITS     = 2
) (
  input  logic i_clock,
  input  logic i_reset,
  input  logic i_uart_rx,      // From host.
  output logic o_uart_tx       // To host.
);

  logic          wire_rate;     // Shared tick.
  logic          wire_rx_done;
  logic          wire_tx_done;
  logic          wire_tx_start;
  data_word_t    wire_data_rx;
  data_word_t    wire_data_tx;
  data_word_t    wire_result;
  alu_operands_t wire_operands;

  baud_rate_generator #(
    .FREC_CLOCK_HZ (FREC_CLOCK_HZ),
    .BAUD_RATE     (BAUD_RATE)
  ) u_baud_rate_generator (
    .i_clock (i_clock),
    .i_reset (i_reset),
    .o_rate  (wire_rate)
  );

  uart_rx u_uart_rx (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_rate     (wire_rate),
    .i_bit_rx   (i_uart_rx),
    .o_rx_done  (wire_rx_done),
    .o_data_out (wire_data_rx)
  );

  uart_tx #(
    .STOP_BITS (STOP_BITS)
  ) u_uart_tx (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_rate     (wire_rate),
    .i_tx_start (wire_tx_start),
    .i_data_in  (wire_data_tx),
    .o_bit_tx   (o_uart_tx),
    .o_tx_done  (wire_tx_done)
  );

  interface_circuit u_interface_circuit (
    .i_clock    (i_clock),
    .i_reset    (i_reset),
    .i_rx_done  (wire_rx_done),
    .i_tx_done  (wire_tx_done),
    .i_data_rx  (wire_data_rx),
    .i_result   (wire_result),
    .o_operands (wire_operands),
    .o_tx_start (wire_tx_start),
    .o_data_tx  (wire_data_tx)
  );

  alu u_alu (
    .i_operands (wire_operands),
    .o_result   (wire_result)
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40           // Full clock period.
) (
  output logic o_clock
);

  initial o_clock = 1'b0;                // Start low.

  // Toggle every half period.
  always #(PERIOD_NS / 2) o_clock = ~o_clock;

endmodule

// ==== tb_top_arquitectura.sv ====
`timescale 1ns/100ps

module tb_top_arquitectura import uart_alu_pkg::*; ();

  localparam int TB_CLOCK_HZ  = 25000000;
  localparam int TB_BAUD_RATE = 156250;
  localparam int TB_STOP_BITS = 2;
  localparam int CLKS_PER_BIT = TB_CLOCK_HZ / TB_BAUD_RATE;   // 160.
  localparam int FRAME_CLKS   = 11 * CLKS_PER_BIT;            // Start, 8 data, 2 stop.
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CLKS    = 2000;
  localparam int GLITCH_CLKS  = CLKS_PER_BIT * 3 / 8;  // Back high before the mid-bit check.
  localparam int REPLY_WAIT   = 4 * FRAME_CLKS;       // Triple plus reply latency.
  localparam int NUM_TRIPLES  = 22;                   // 8 fixed, 12 random, unknown, glitch.
  localparam int STIM_CLKS    = RESET_CYCLES + IDLE_CLKS + GLITCH_CLKS + 2 * FRAME_CLKS
                                + NUM_TRIPLES * 4 * FRAME_CLKS;
  localparam int TIMEOUT_CYCLES = STIM_CLKS * 6 / 5;  // About 120 percent.

  localparam data_word_t OPCODES [8] = '{8'h20, 8'h22, 8'h24, 8'h25,
                                         8'h26, 8'h27, 8'h03, 8'h02};
  // Carry for ADD, borrow for SUB, sign fill for SRA (B low bits give 3).
  localparam data_word_t FIXED_A [8] = '{8'hF0, 8'h10, 8'hCA, 8'hA0,
                                         8'hFF, 8'h12, 8'h90, 8'h90};
  localparam data_word_t FIXED_B [8] = '{8'h25, 8'h20, 8'h6F, 8'h05,
                                         8'h5A, 8'h34, 8'h0B, 8'h02};

  logic i_clock;
  logic i_reset;
  logic i_uart_rx;
  logic o_uart_tx;

  int check_count;
  int error_count;
  int cycle_count;
  int seed;
  int rnd_a;
  int rnd_b;
  int rnd_op;

  tb_clock_gen #(.PERIOD_NS (40)) u_clock_gen (.o_clock (i_clock));

  top_arquitectura #(
    .FREC_CLOCK_HZ (TB_CLOCK_HZ),
    .BAUD_RATE     (TB_BAUD_RATE),
    .STOP_BITS     (TB_STOP_BITS)
  ) u_dut (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_uart_rx (i_uart_rx),
    .o_uart_tx (o_uart_tx)
  );

  //////////////////////////////
  // Reference model.
  //////////////////////////////

  function automatic data_word_t reference_result(input data_word_t a, input data_word_t b,
                                                  input data_word_t op);
    logic [15:0] ext;                    // Sign-extended A for SRA.
    data_word_t  res;
    ext = {{8{a[7]}}, a} >> b[2:0];
    case (op)
      8'h20:   res = a + b;              // Mod 256.
      8'h22:   res = a - b;
      8'h24:   res = a & b;
      8'h25:   res = a | b;
      8'h26:   res = a ^ b;
      8'h27:   res = ~(a | b);
      8'h03:   res = ext[7:0];
      8'h02:   res = a >> b[2:0];
      default: res = 8'h00;              // Unknown opcode.
    endcase
    return res;
  endfunction

  //////////////////////////////
  // Checks and serial tasks.
  //////////////////////////////

  task automatic compare_value(input string name, input data_word_t expected,
                               input data_word_t got);
    check_count++;
    assert (got === expected) else begin
      error_count++;
      $display("mismatch at %0t ns: %s expected %h got %h", $time, name, expected, got);
    end
  endtask

  // Line must stay high. Stops at the first low sample.
  task automatic check_line_idle(input int cycles);
    logic level;
    level = 1'b1;
    for (int i = 0; i < cycles && level === 1'b1; i++) begin
      @(negedge i_clock);
      level = o_uart_tx;
    end
    compare_value("o_uart_tx idle", 8'h01, {7'd0, level});
  endtask

  task automatic drive_bit(input logic value);
    i_uart_rx = value;                   // Called on a falling edge.
    repeat (CLKS_PER_BIT) @(negedge i_clock);
  endtask

  task automatic send_frame(input data_word_t data);
    drive_bit(1'b0);                     // Start bit.
    for (int i = 0; i < 8; i++) drive_bit(data[i]);   // LSB first.
    drive_bit(1'b1);
    drive_bit(1'b1);                     // Two stop bits.
  endtask

  task automatic receive_frame(output data_word_t data, output logic start_bit,
                               output logic [1:0] stop_bits, output logic seen);
    int waited;
    waited    = 0;
    data      = '0;
    start_bit = 1'b1;
    stop_bits = 2'b00;
    seen      = 1'b0;
    while (o_uart_tx === 1'b1 && waited < REPLY_WAIT) begin
      @(negedge i_clock);
      waited++;
    end
    if (o_uart_tx === 1'b0) begin
      seen = 1'b1;
      repeat (CLKS_PER_BIT / 2) @(negedge i_clock);   // Middle of start bit.
      start_bit = o_uart_tx;
      for (int i = 0; i < 8; i++) begin
        repeat (CLKS_PER_BIT) @(negedge i_clock);
        data[i] = o_uart_tx;
      end
      for (int s = 0; s < 2; s++) begin
        repeat (CLKS_PER_BIT) @(negedge i_clock);
        stop_bits[s] = o_uart_tx;
      end
    end
  endtask

  // Send A, B, opcode while listening for the reply.
  task automatic run_triple(input data_word_t a, input data_word_t b, input data_word_t op);
    data_word_t reply;
    logic       start_bit;
    logic [1:0] stop_bits;
    logic       seen;
    fork
      begin
        send_frame(a);
        send_frame(b);
        send_frame(op);
      end
      receive_frame(reply, start_bit, stop_bits, seen);
    join
    check_count++;
    assert (seen) else begin
      error_count++;
      $display("no reply frame started within %0d cycles, at %0t ns", REPLY_WAIT, $time);
    end
    if (seen) begin
      compare_value("o_uart_tx start bit", 8'h00, {7'd0, start_bit});
      compare_value("o_uart_tx reply byte", reference_result(a, b, op), reply);
      compare_value("o_uart_tx stop bit 1", 8'h01, {7'd0, stop_bits[0]});
      compare_value("o_uart_tx stop bit 2", 8'h01, {7'd0, stop_bits[1]});
      repeat (CLKS_PER_BIT) @(negedge i_clock);        // Past end of frame.
      compare_value("o_uart_tx after frame", 8'h01, {7'd0, o_uart_tx});
    end
  endtask

  //////////////////////////////
  // Stimulus.
  //////////////////////////////

  initial begin
    seed        = 64;
    check_count = 0;
    error_count = 0;
    i_reset     = 1'b1;
    i_uart_rx   = 1'b1;                  // Line idles high.
    repeat (RESET_CYCLES) @(negedge i_clock);
    i_reset = 1'b0;

    check_line_idle(IDLE_CLKS);          // Quiet after reset.

    for (int i = 0; i < 8; i++) run_triple(FIXED_A[i], FIXED_B[i], OPCODES[i]);

    for (int i = 0; i < 12; i++) begin
      rnd_a  = $random(seed);
      rnd_b  = $random(seed);
      rnd_op = $random(seed);
      run_triple(rnd_a[7:0], rnd_b[7:0], OPCODES[rnd_op[2:0]]);
    end

    run_triple(8'h3C, 8'hA5, 8'h55);     // Unknown opcode.

    // Short low pulse that the receiver drops at mid-bit.
    i_uart_rx = 1'b0;
    repeat (GLITCH_CLKS) @(negedge i_clock);
    i_uart_rx = 1'b1;
    check_line_idle(2 * FRAME_CLKS);
    run_triple(8'h81, 8'h14, 8'h20);     // Still aligned on A, nonzero sum.

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // Watchdog.
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge i_clock);
      cycle_count++;
    end
    $display("timeout, the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== sources.f ====
uart_alu_pkg.sv
baud_rate_generator.sv
uart_rx.sv
uart_tx.sv
alu.sv
interface_circuit.sv
top_arquitectura.sv
tb_clock_gen.sv
tb_top_arquitectura.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_top_arquitectura -f sources.f -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "Build or run error, see build.log and sim.log."; exit 1; }
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "Simulation passed." ||
{ echo "Simulation failed, see sim.log."; exit 1; }
